/* Makefile */
# Verilator build and run for the secure shared-memory subsystem

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_sec_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/mem_access_ctrl.sv */
// Security check between the arbiter and the word store. Holds the
// partition boundary: insecure requests only reach memory below it,
// address 0 is the boundary register itself and is secure-only.

`default_nettype none

`include "mem_sec_params.svh"

module mem_access_ctrl (
	input  wire                      clk,
	input  wire                      reset,

	input  mem_sec_pkg::mem_req_t    req,
	input  wire                      req_val,
	output logic                     req_rdy,

	output mem_sec_pkg::mem_resp_t   resp,
	output logic                     resp_val,
	input  wire                      resp_rdy,

	output mem_sec_pkg::store_req_t  store_req,
	output logic                     store_req_val,
	input  wire [`MEM_DATA_BITS-1:0] store_resp_data,
	input  wire                      store_resp_val
);

	typedef enum logic [2:0] {
		IDLE,
		CHECK,
		MEM_ACCESS,
		MEM_WAIT,
		RESPOND
	} state_t;

	state_t state_q;
	state_t state_next;

	mem_sec_pkg::mem_req_t     req_q;
	mem_sec_pkg::mem_resp_t    resp_q;
	mem_sec_pkg::mem_resp_t    check_resp;
	mem_sec_pkg::mem_resp_t    mem_resp;
	mem_sec_pkg::data_word_u   part_word;
	logic [`MEM_ADDR_BITS-1:0] part_q;

	logic part_hit;
	logic above_part;
	logic part_access;
	logic part_write;
	logic fake_access;

	//----------------------------------------------------------------------
	// decision made in CHECK
	//----------------------------------------------------------------------

	assign part_hit    = (req_q.addr == `MEM_ADDR_BITS'(`MEM_PART_ADDR));
	assign above_part  = (req_q.addr >= part_q);
	assign part_access = part_hit && req_q.sec_level;
	assign part_write  = part_access && (req_q.mem_type == mem_sec_pkg::MEM_WRITE);
	// insecure domain blocked from the register and the secure region
	assign fake_access = !req_q.sec_level && (part_hit || above_part);

	always_comb begin
		state_next = state_q;
		case (state_q)
			IDLE:
				if (req_val) state_next = CHECK;
			CHECK:
				if (part_access || fake_access) state_next = RESPOND;
				else state_next = MEM_ACCESS;
			MEM_ACCESS:
				state_next = MEM_WAIT;
			MEM_WAIT:
				if (store_resp_val) state_next = resp_rdy ? IDLE : RESPOND;
			RESPOND:
				if (resp_rdy) state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	// register read-back, a write returns the new boundary
	always_comb begin
		part_word.raw          = '0;
		part_word.cfg.boundary = part_write ? req_q.data.cfg.boundary : part_q;
	end

	// response for the register and blocked paths
	always_comb begin
		check_resp.mem_type  = req_q.mem_type;
		check_resp.opaque    = req_q.opaque;
		check_resp.data      = fake_access ? '0 : part_word.raw;
		check_resp.sec_level = req_q.sec_level;
		check_resp.insecure  = fake_access;
	end

	// response straight from the store, region level from the boundary
	always_comb begin
		mem_resp.mem_type  = req_q.mem_type;
		mem_resp.opaque    = req_q.opaque;
		mem_resp.data      = store_resp_data;
		mem_resp.sec_level = above_part;
		mem_resp.insecure  = 1'b0;
	end

	//----------------------------------------------------------------------
	// state, boundary and payload registers
	//----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			part_q  <= `MEM_INIT_PART;
		end else begin
			state_q <= state_next;
			if (state_q == CHECK && part_write) begin
				part_q <= req_q.data.cfg.boundary;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_val && req_rdy) begin
			req_q <= req;
		end
		if (state_q == CHECK) begin
			resp_q <= check_resp;
		end else if (state_q == MEM_WAIT && store_resp_val) begin
			// kept in case the response is stalled
			resp_q <= mem_resp;
		end
	end

	//----------------------------------------------------------------------
	// outputs
	//----------------------------------------------------------------------

	assign req_rdy = (state_q == IDLE);

	always_comb begin
		store_req.wen   = (req_q.mem_type == mem_sec_pkg::MEM_WRITE);
		store_req.index = req_q.addr[`MEM_ADDR_BITS-1:2];
		store_req.data  = req_q.data.raw;
	end

	assign store_req_val = (state_q == MEM_ACCESS);

	// store data passes through in MEM_WAIT, held copy afterwards
	assign resp     = (state_q == MEM_WAIT) ? mem_resp : resp_q;
	assign resp_val = (state_q == RESPOND) || (state_q == MEM_WAIT && store_resp_val);

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
// Round-robin arbiter placing the requester ports onto the single
// access controller channel. One transaction in flight; the grant is held
// until the response leaves on the same port.

`default_nettype none

`include "mem_sec_params.svh"

module mem_arbiter (
	input  wire                    clk,
	input  wire                    reset,

	input  mem_sec_pkg::mem_req_t  port_req [`MEM_NUM_PORTS],
	input  wire [`MEM_NUM_PORTS-1:0] port_req_val,
	output logic [`MEM_NUM_PORTS-1:0] port_req_rdy,

	output mem_sec_pkg::mem_resp_t port_resp [`MEM_NUM_PORTS],
	output logic [`MEM_NUM_PORTS-1:0] port_resp_val,
	input  wire [`MEM_NUM_PORTS-1:0] port_resp_rdy,

	output mem_sec_pkg::mem_req_t  ctrl_req,
	output logic                   ctrl_req_val,
	input  wire                    ctrl_req_rdy,

	input  mem_sec_pkg::mem_resp_t ctrl_resp,
	input  wire                    ctrl_resp_val,
	output logic                   ctrl_resp_rdy
);

	localparam int N        = `MEM_NUM_PORTS;
	localparam int IDX_BITS = (N > 1) ? $clog2(N) : 1;

	logic                busy_q;
	logic [IDX_BITS-1:0] grant_q;
	logic [IDX_BITS-1:0] prio_q;
	logic [IDX_BITS-1:0] pick;
	logic                any_val;
	logic                req_fire;
	logic                resp_fire;

	//----------------------------------------------------------------------
	// pick the first requester starting at the priority pointer
	//----------------------------------------------------------------------

	always_comb begin
		int cand;
		pick    = prio_q;
		any_val = 1'b0;
		// walk backwards so the pointer itself wins last
		for (int i = N - 1; i >= 0; i--) begin
			cand = (int'(prio_q) + i) % N;
			if (port_req_val[cand]) begin
				pick    = IDX_BITS'(cand);
				any_val = 1'b1;
			end
		end
	end

	// request side, nothing forwarded while a transaction is open
	assign ctrl_req     = port_req[pick];
	assign ctrl_req_val = !busy_q && any_val;
	assign req_fire     = ctrl_req_val && ctrl_req_rdy;

	always_comb begin
		for (int p = 0; p < N; p++) begin
			port_req_rdy[p] = !busy_q && any_val && ctrl_req_rdy && (pick == IDX_BITS'(p));
		end
	end

	//----------------------------------------------------------------------
	// response steering back to the granted port
	//----------------------------------------------------------------------

	always_comb begin
		for (int p = 0; p < N; p++) begin
			port_resp[p]     = (grant_q == IDX_BITS'(p)) ? ctrl_resp : '0;
			port_resp_val[p] = busy_q && ctrl_resp_val && (grant_q == IDX_BITS'(p));
		end
	end

	assign ctrl_resp_rdy = busy_q && port_resp_rdy[grant_q];
	assign resp_fire     = ctrl_resp_val && ctrl_resp_rdy;

	// grant, busy and priority pointer
	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q  <= 1'b0;
			grant_q <= '0;
			prio_q  <= '0;
		end else if (req_fire) begin
			busy_q  <= 1'b1;
			grant_q <= pick;
		end else if (resp_fire) begin
			busy_q <= 1'b0;
			// other port goes first next time
			prio_q <= (grant_q == IDX_BITS'(N - 1)) ? '0 : grant_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/mem_sec_params.svh */
// Global sizes and reset values for the secure shared-memory subsystem.
// Included by the package and by every module that needs a width or a depth.

`ifndef MEM_SEC_PARAMS_SVH
`define MEM_SEC_PARAMS_SVH

// byte address width
`define MEM_ADDR_BITS 12

// data word width
`define MEM_DATA_BITS 32

// opaque tag carried from request to response
`define MEM_OPAQUE_BITS 8

// word memory depth, indexed by address bits 11:2
`define MEM_WORDS 1024

// partition boundary after reset, everything at or above is secure
`define MEM_INIT_PART 12'hc00

// address of the partition control register
`define MEM_PART_ADDR 0

// requester ports on the arbiter
`define MEM_NUM_PORTS 2

`endif

/* hw/mem_sec_pkg.sv */
// Shared types for the secure shared-memory subsystem.
// Modules refer to these by scoped name, e.g. mem_sec_pkg::mem_req_t.

`default_nettype none

`include "mem_sec_params.svh"

package mem_sec_pkg;

	// word index width into the store
	localparam int MEM_INDEX_BITS = $clog2(`MEM_WORDS);

	//----------------------------------------------------------------------
	// request / response fields
	//----------------------------------------------------------------------

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_type_t;

	// layout of the partition control register
	typedef struct packed {
		logic [`MEM_DATA_BITS-`MEM_ADDR_BITS-1:0] rsvd;
		logic [`MEM_ADDR_BITS-1:0]                boundary;
	} part_cfg_t;

	// a write to the partition address reads its word as a config,
	// all other accesses treat it as plain memory data
	typedef union packed {
		logic [`MEM_DATA_BITS-1:0] raw;
		part_cfg_t                 cfg;
	} data_word_u;

	typedef struct packed {
		mem_type_t                   mem_type;
		logic [`MEM_OPAQUE_BITS-1:0] opaque;
		logic [`MEM_ADDR_BITS-1:0]   addr;
		data_word_u                  data;
		logic                        sec_level;
	} mem_req_t;

	typedef struct packed {
		mem_type_t                   mem_type;
		logic [`MEM_OPAQUE_BITS-1:0] opaque;
		logic [`MEM_DATA_BITS-1:0]   data;
		logic                        sec_level;
		logic                        insecure;
	} mem_resp_t;

	//----------------------------------------------------------------------
	// controller to store
	//----------------------------------------------------------------------

	typedef struct packed {
		logic                      wen;
		logic [MEM_INDEX_BITS-1:0] index;
		logic [`MEM_DATA_BITS-1:0] data;
	} store_req_t;

endpackage

`default_nettype wire

/* hw/mem_sec_top.sv */
// Top level of the secure shared-memory subsystem: arbiter, access
// controller and word store. Requesters connect to the port-side arrays.

`default_nettype none

`include "mem_sec_params.svh"

module mem_sec_top (
	input  wire                      clk,
	input  wire                      reset,

	input  mem_sec_pkg::mem_req_t    port_req [`MEM_NUM_PORTS],
	input  wire [`MEM_NUM_PORTS-1:0] port_req_val,
	output logic [`MEM_NUM_PORTS-1:0] port_req_rdy,

	output mem_sec_pkg::mem_resp_t   port_resp [`MEM_NUM_PORTS],
	output logic [`MEM_NUM_PORTS-1:0] port_resp_val,
	input  wire [`MEM_NUM_PORTS-1:0] port_resp_rdy
);

	// arbiter <-> access controller
	mem_sec_pkg::mem_req_t   ctrl_req;
	logic                    ctrl_req_val;
	logic                    ctrl_req_rdy;
	mem_sec_pkg::mem_resp_t  ctrl_resp;
	logic                    ctrl_resp_val;
	logic                    ctrl_resp_rdy;

	// access controller <-> store
	mem_sec_pkg::store_req_t   store_req;
	logic                      store_req_val;
	logic [`MEM_DATA_BITS-1:0] store_resp_data;
	logic                      store_resp_val;

	mem_arbiter arbiter (
		.clk           (clk),
		.reset         (reset),
		.port_req      (port_req),
		.port_req_val  (port_req_val),
		.port_req_rdy  (port_req_rdy),
		.port_resp     (port_resp),
		.port_resp_val (port_resp_val),
		.port_resp_rdy (port_resp_rdy),
		.ctrl_req      (ctrl_req),
		.ctrl_req_val  (ctrl_req_val),
		.ctrl_req_rdy  (ctrl_req_rdy),
		.ctrl_resp     (ctrl_resp),
		.ctrl_resp_val (ctrl_resp_val),
		.ctrl_resp_rdy (ctrl_resp_rdy)
	);

	mem_access_ctrl access_ctrl (
		.clk             (clk),
		.reset           (reset),
		.req             (ctrl_req),
		.req_val         (ctrl_req_val),
		.req_rdy         (ctrl_req_rdy),
		.resp            (ctrl_resp),
		.resp_val        (ctrl_resp_val),
		.resp_rdy        (ctrl_resp_rdy),
		.store_req       (store_req),
		.store_req_val   (store_req_val),
		.store_resp_data (store_resp_data),
		.store_resp_val  (store_resp_val)
	);

	mem_store store (
		.clk             (clk),
		.store_req       (store_req),
		.store_req_val   (store_req_val),
		.store_resp_data (store_resp_data),
		.store_resp_val  (store_resp_val)
	);

endmodule

`default_nettype wire

/* hw/mem_store.sv */
// Single-port word memory behind the access controller.
// Always ready; each access answers exactly one cycle later.

`default_nettype none

`include "mem_sec_params.svh"

module mem_store (
	input  wire                       clk,

	input  mem_sec_pkg::store_req_t   store_req,
	input  wire                       store_req_val,

	output logic [`MEM_DATA_BITS-1:0] store_resp_data,
	output logic                      store_resp_val
);

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------

	// contents undefined until written
	logic [`MEM_DATA_BITS-1:0] mem [`MEM_WORDS];

	always_ff @(posedge clk) begin
		if (store_req_val && store_req.wen) begin
			mem[store_req.index] <= store_req.data;
		end
	end

	//----------------------------------------------------------------------
	// registered response
	//----------------------------------------------------------------------

	// write answers with the data just stored
	always_ff @(posedge clk) begin
		if (store_req_val) begin
			if (store_req.wen) begin
				store_resp_data <= store_req.data;
			end else begin
				store_resp_data <= mem[store_req.index];
			end
		end
	end

	// follows the request by one cycle, low whenever the request was low
	always_ff @(posedge clk) begin
		store_resp_val <= store_req_val;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/mem_sec_pkg.sv
hw/mem_arbiter.sv
hw/mem_access_ctrl.sv
hw/mem_store.sv
hw/mem_sec_top.sv
testbench/mem_sec_checker.sv
testbench/mem_sec_assert.sv
testbench/mem_sec_tb.sv

/* testbench/mem_sec_assert.sv */
// Concurrent checks on the access controller handshakes.
// Bound into every mem_access_ctrl instance from the bind below.

`default_nettype none

module mem_sec_assert (
	input wire                    clk,
	input wire                    reset,
	input mem_sec_pkg::mem_resp_t resp,
	input wire                    resp_val,
	input wire                    resp_rdy
);

	// a stalled response stays valid until taken
	resp_held: assert property (@(posedge clk) disable iff (reset)
		resp_val && !resp_rdy |=> resp_val)
		else $error("response valid dropped while stalled");

	// payload frozen while stalled
	resp_stable: assert property (@(posedge clk) disable iff (reset)
		resp_val && !resp_rdy |=> $stable(resp))
		else $error("response payload changed while stalled");

	resp_quiet_in_reset: assert property (@(posedge clk)
		reset |=> !resp_val)
		else $error("response valid high during reset");

endmodule

bind mem_access_ctrl mem_sec_assert handshake_checks (
	.clk      (clk),
	.reset    (reset),
	.resp     (resp),
	.resp_val (resp_val),
	.resp_rdy (resp_rdy)
);

`default_nettype wire

/* testbench/mem_sec_checker.sv */
// Response scoreboard for the port side. Matches each response to its
// table row by opaque tag, prints one line per finished test and checks
// the round-robin order of request grants.

`default_nettype none

`include "mem_sec_params.svh"

module mem_sec_checker #(
	parameter int NUM_ROWS = 1
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire [`MEM_NUM_PORTS-1:0] port_req_val,
	input  wire [`MEM_NUM_PORTS-1:0] port_req_rdy,
	input  mem_sec_pkg::mem_resp_t   port_resp [`MEM_NUM_PORTS],
	input  wire [`MEM_NUM_PORTS-1:0] port_resp_val,
	input  wire [`MEM_NUM_PORTS-1:0] port_resp_rdy,
	input  mem_sec_pkg::mem_resp_t   exp_resp [NUM_ROWS],
	input  wire [NUM_ROWS-1:0]       exp_port,
	output int                       done_count,
	output int                       fail_count
);

	logic [NUM_ROWS-1:0] seen;
	int                  last_grant;

	// sampled mid-cycle while the transfer itself waits for the next rising edge
	always @(negedge clk) begin : watch
		int                     tag;
		int                     next_port;
		mem_sec_pkg::mem_resp_t got;
		if (reset) begin
			seen       = '0;
			done_count = 0;
			fail_count = 0;
			last_grant = `MEM_NUM_PORTS - 1;
		end else begin
			// the port after the last one granted has priority
			for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
				if (port_req_val[p] && port_req_rdy[p]) begin
					next_port = (last_grant + 1) % `MEM_NUM_PORTS;
					if (p != next_port && port_req_val[next_port]) begin
						$display("port %0d was granted while port %0d had priority",
							p, next_port);
						fail_count++;
					end
					last_grant = p;
				end
			end
			for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
				if (port_resp_val[p] && port_resp_rdy[p]) begin
					got = port_resp[p];
					tag = int'(got.opaque);
					done_count++;
					if (tag >= NUM_ROWS) begin
						$display("response on port %0d carries unknown tag %0d", p, tag);
						fail_count++;
					end else if (seen[tag]) begin
						$display("second response for test %0d on port %0d", tag, p);
						fail_count++;
					end else if (int'(exp_port[tag]) != p) begin
						$display("response for test %0d came back on the wrong port %0d", tag, p);
						fail_count++;
					end else if (got !== exp_resp[tag]) begin
						$display("Fail at %0t: test %0d got data %h ins %b sec %b type %b, %s",
							$time, tag, got.data, got.insecure, got.sec_level, got.mem_type,
							$sformatf("expected data %h ins %b sec %b type %b",
							exp_resp[tag].data, exp_resp[tag].insecure,
							exp_resp[tag].sec_level, exp_resp[tag].mem_type));
						fail_count++;
					end else begin
						$display("test %0d on port %0d ok, data %h", tag, p, got.data);
					end
					if (tag < NUM_ROWS) begin
						seen[tag] = 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/mem_sec_tb.sv */
// Testbench for the secure shared-memory subsystem. Runs a table of
// requests over both ports under random response back-pressure; the
// comparison itself happens in mem_sec_checker.

`default_nettype none

`include "mem_sec_params.svh"

module mem_sec_tb;

	localparam int NUM_ROWS       = 27;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int STIM_DELAY     = 1;

	logic clk = 1'b0;
	logic reset;

	mem_sec_pkg::mem_req_t     port_req [`MEM_NUM_PORTS];
	logic [`MEM_NUM_PORTS-1:0] port_req_val;
	logic [`MEM_NUM_PORTS-1:0] port_req_rdy;
	mem_sec_pkg::mem_resp_t    port_resp [`MEM_NUM_PORTS];
	logic [`MEM_NUM_PORTS-1:0] port_resp_val;
	logic [`MEM_NUM_PORTS-1:0] port_resp_rdy;

	// stimulus table whose row number doubles as the opaque tag
	mem_sec_pkg::mem_req_t  row_req [NUM_ROWS];
	mem_sec_pkg::mem_resp_t row_exp [NUM_ROWS];
	logic [NUM_ROWS-1:0]    row_port;
	logic [NUM_ROWS-1:0]    row_pair;
	int                     row_count;

	int          done_count;
	int          fail_count;
	logic        timed_out;
	logic [31:0] lfsr = 32'h6d2f;

	always #50 clk = ~clk;

	mem_sec_top uut (
		.clk           (clk),
		.reset         (reset),
		.port_req      (port_req),
		.port_req_val  (port_req_val),
		.port_req_rdy  (port_req_rdy),
		.port_resp     (port_resp),
		.port_resp_val (port_resp_val),
		.port_resp_rdy (port_resp_rdy)
	);

	mem_sec_checker #(.NUM_ROWS(NUM_ROWS)) resp_check (
		.clk           (clk),
		.reset         (reset),
		.port_req_val  (port_req_val),
		.port_req_rdy  (port_req_rdy),
		.port_resp     (port_resp),
		.port_resp_val (port_resp_val),
		.port_resp_rdy (port_resp_rdy),
		.exp_resp      (row_exp),
		.exp_port      (row_port),
		.done_count    (done_count),
		.fail_count    (fail_count)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// random response back-pressure with one lfsr bit per cycle
	always @(posedge clk) begin : resp_ready_gen
		logic active;
		active = !reset;
		#(STIM_DELAY);
		if (active) begin
			lfsr          = lfsr_step(lfsr);
			port_resp_rdy = {`MEM_NUM_PORTS{lfsr[0]}};
		end
	end

	task automatic add_row(input logic port, input logic pair, input logic sec,
			input logic wr, input logic [11:0] addr, input logic [31:0] data,
			input logic [31:0] exp_data, input logic exp_ins, input logic exp_sec);
		int n;
		n = row_count;
		row_req[n].mem_type  = wr ? mem_sec_pkg::MEM_WRITE : mem_sec_pkg::MEM_READ;
		row_req[n].opaque    = `MEM_OPAQUE_BITS'(n);
		row_req[n].addr      = addr;
		row_req[n].data.raw  = data;
		row_req[n].sec_level = sec;
		row_exp[n].mem_type  = row_req[n].mem_type;
		row_exp[n].opaque    = `MEM_OPAQUE_BITS'(n);
		row_exp[n].data      = exp_data;
		row_exp[n].sec_level = exp_sec;
		row_exp[n].insecure  = exp_ins;
		row_port[n]          = port;
		row_pair[n]          = pair;
		row_count++;
	endtask

	// issue one row, or two rows at once on different ports
	task automatic run_rows(input int first, input int count);
		logic [`MEM_NUM_PORTS-1:0] pending;
		logic [`MEM_NUM_PORTS-1:0] fired;
		int                        target;
		int                        cycles;
		pending = '0;
		target  = done_count + count;
		for (int k = 0; k < count; k++) begin
			port_req[row_port[first + k]] = row_req[first + k];
			pending[row_port[first + k]]  = 1'b1;
		end
		port_req_val = pending;
		cycles       = 0;
		while (pending != '0 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			fired = pending & port_req_rdy;
			@(posedge clk);
			#(STIM_DELAY);
			pending      = pending & ~fired;
			port_req_val = pending;
			cycles++;
		end
		if (pending != '0) begin
			$display("timeout: request of test %0d was never accepted", first);
			timed_out = 1'b1;
		end else begin
			cycles = 0;
			while (done_count < target && cycles < TIMEOUT_CYCLES) begin
				@(posedge clk);
				#(STIM_DELAY);
				cycles++;
			end
			if (done_count < target) begin
				$display("timeout: no response for test %0d", first);
				timed_out = 1'b1;
			end
		end
	endtask

	initial begin
		int i;
		reset         = 1'b1;
		port_req_val  = '0;
		port_resp_rdy = '0;
		timed_out     = 1'b0;
		row_count     = 0;
		for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
			port_req[p] = '0;
		end

		// port pair sec wr addr data exp_data exp_ins exp_sec
		add_row(1'b0, 1'b0, 1'b1, 1'b1, 12'h010, 32'h1111_0010, 32'h1111_0010, 1'b0, 1'b0);
		add_row(1'b0, 1'b0, 1'b1, 1'b0, 12'h010, 32'h0, 32'h1111_0010, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, 1'b1, 1'b1, 12'hc40, 32'ha5a5_c040, 32'ha5a5_c040, 1'b0, 1'b1);
		add_row(1'b1, 1'b0, 1'b1, 1'b0, 12'hc40, 32'h0, 32'ha5a5_c040, 1'b0, 1'b1);
		add_row(1'b1, 1'b0, 1'b0, 1'b1, 12'h200, 32'h5a5a_0200, 32'h5a5a_0200, 1'b0, 1'b0);
		add_row(1'b0, 1'b0, 1'b0, 1'b0, 12'h200, 32'h0, 32'h5a5a_0200, 1'b0, 1'b0);
		// blocked insecure accesses leave memory and boundary untouched
		add_row(1'b0, 1'b0, 1'b0, 1'b1, 12'hc40, 32'hdead_beef, 32'h0, 1'b1, 1'b0);
		add_row(1'b1, 1'b0, 1'b0, 1'b0, 12'hc40, 32'h0, 32'h0, 1'b1, 1'b0);
		add_row(1'b0, 1'b0, 1'b1, 1'b0, 12'hc40, 32'h0, 32'ha5a5_c040, 1'b0, 1'b1);
		add_row(1'b1, 1'b0, 1'b0, 1'b1, 12'h000, 32'h0000_0800, 32'h0, 1'b1, 1'b0);
		add_row(1'b0, 1'b0, 1'b1, 1'b0, 12'h000, 32'h0, 32'h0000_0c00, 1'b0, 1'b1);
		// boundary moved down to 0x800
		add_row(1'b1, 1'b0, 1'b1, 1'b1, 12'h000, 32'h0000_0800, 32'h0000_0800, 1'b0, 1'b1);
		add_row(1'b0, 1'b0, 1'b1, 1'b0, 12'h000, 32'h0, 32'h0000_0800, 1'b0, 1'b1);
		add_row(1'b0, 1'b0, 1'b0, 1'b1, 12'h7fc, 32'h0bad_f00d, 32'h0bad_f00d, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, 1'b0, 1'b0, 12'h7fc, 32'h0, 32'h0bad_f00d, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, 1'b1, 1'b1, 12'h900, 32'h1234_0900, 32'h1234_0900, 1'b0, 1'b1);
		add_row(1'b0, 1'b0, 1'b0, 1'b0, 12'h900, 32'h0, 32'h0, 1'b1, 1'b0);
		add_row(1'b0, 1'b0, 1'b0, 1'b1, 12'h900, 32'hffff_ffff, 32'h0, 1'b1, 1'b0);
		add_row(1'b0, 1'b0, 1'b1, 1'b0, 12'h900, 32'h0, 32'h1234_0900, 1'b0, 1'b1);
		// both ports at once
		add_row(1'b0, 1'b1, 1'b0, 1'b1, 12'h100, 32'h0100_0100, 32'h0100_0100, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, 1'b0, 1'b1, 12'h104, 32'h0104_0104, 32'h0104_0104, 1'b0, 1'b0);
		add_row(1'b0, 1'b1, 1'b0, 1'b0, 12'h104, 32'h0, 32'h0104_0104, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, 1'b0, 1'b0, 12'h100, 32'h0, 32'h0100_0100, 1'b0, 1'b0);
		add_row(1'b0, 1'b0, 1'b1, 1'b0, 12'h7fc, 32'h0, 32'h0bad_f00d, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, 1'b0, 1'b0, 12'h900, 32'h0, 32'h0, 1'b1, 1'b0);
		add_row(1'b1, 1'b1, 1'b1, 1'b1, 12'h000, 32'h0000_0c00, 32'h0000_0c00, 1'b0, 1'b1);
		add_row(1'b0, 1'b0, 1'b1, 1'b0, 12'h010, 32'h0, 32'h1111_0010, 1'b0, 1'b0);

		repeat (16) @(posedge clk);
		#(STIM_DELAY);
		reset = 1'b0;

		i = 0;
		while (i < row_count && !timed_out) begin
			if (row_pair[i]) begin
				run_rows(i, 2);
				i += 2;
			end else begin
				run_rows(i, 1);
				i++;
			end
		end

		$display("summary: %0d tests, %0d responses, %0d errors", row_count, done_count,
			fail_count);
		if (!timed_out && fail_count == 0 && done_count == row_count) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
